/* design/coreParamsPkg.sv */
package coreParamsPkg;

	// ************************************************************
	// issue queue geometry
	// ************************************************************

	localparam int NUM_ENTRIES = 8; // slots in the issue queue.

	localparam int IDX_WIDTH = $clog2(NUM_ENTRIES); // enough bits to name one slot.

	// ************************************************************
	// tags and ages
	// ************************************************************

	localparam int TAG_WIDTH = 6; // physical register tag.

	localparam int AGE_WIDTH = 4; // per-entry wait counter.

	// Counter stops here, so long-waiting entries tie and the lower slot wins.
	localparam logic [AGE_WIDTH-1:0] AGE_MAX = '1;

endpackage

/* design/uopPkg.sv */
package uopPkg;

	import coreParamsPkg::*;

	// ************************************************************
	// micro-op payload
	// ************************************************************

	localparam int OP_WIDTH = 8; // opcode field carried through untouched.

	typedef struct packed {
		logic [OP_WIDTH-1:0]  opcode;
		logic [TAG_WIDTH-1:0] srcTag; // the single source operand.
		logic                 srcReady; // source already produced at dispatch.
		logic [TAG_WIDTH-1:0] dstTag;
	} uopT;

	// ************************************************************
	// queue entry
	// ************************************************************

	typedef struct packed {
		logic                 valid;
		logic                 ready; // source available, entry may issue.
		logic [AGE_WIDTH-1:0] age; // edges spent waiting, saturating.
		uopT                  uop;
	} entryT;

endpackage

/* design/prioritySelect.sv */
`timescale 1ns/1ps

module prioritySelect import coreParamsPkg::*; #(
	parameter int RADIX = NUM_ENTRIES
)(
	input  logic [RADIX-1:0]         reqs_i,
	output logic [RADIX-1:0]         grant_o,
	output logic [$clog2(RADIX)-1:0] grantIdx_o,
	output logic                     any_o
);

	localparam int IDX_W = $clog2(RADIX);

	logic [RADIX-1:0] noLower; // bit i is set while no request sits below i.

	assign noLower[0] = 1'b1;

	for (genvar i = 1; i < RADIX; i++) begin : gChain
		assign noLower[i] = noLower[i-1] & ~reqs_i[i-1];
	end

	assign grant_o = reqs_i & noLower; // at most one bit survives.

	// The grant is one-hot, so OR-ing the positions of set bits gives the index.
	always_comb begin
		grantIdx_o = '0;
		for (int i = 0; i < RADIX; i++) begin
			if (grant_o[i]) begin
				grantIdx_o = grantIdx_o | IDX_W'(i);
			end
		end
	end

	assign any_o = |reqs_i;

endmodule

/* design/oldestSelect.sv */
`timescale 1ns/1ps

module oldestSelect import coreParamsPkg::*; #(
	parameter int RADIX = NUM_ENTRIES
)(
	input  logic [RADIX-1:0]                elig_i,
	input  logic [RADIX-1:0][AGE_WIDTH-1:0] ages_i,
	output logic [AGE_WIDTH-1:0]            age_o,
	output logic [IDX_WIDTH-1:0]            idx_o,
	output logic                            found_o
);

	if (RADIX == 1) begin : gLeaf

		assign age_o   = ages_i[0];
		assign idx_o   = '0; // the offset is added on the way up.
		assign found_o = elig_i[0];

	end else begin : gNode

		localparam int LO = RADIX / 2;
		localparam int HI = RADIX - LO;

		logic [AGE_WIDTH-1:0] loAge, hiAge;
		logic [IDX_WIDTH-1:0] loIdx, hiIdx;
		logic                 loFound, hiFound;
		logic                 takeHi;

		oldestSelect #(.RADIX(LO)) lower (
			.elig_i (elig_i[LO-1:0]),
			.ages_i (ages_i[LO-1:0]),
			.age_o  (loAge),
			.idx_o  (loIdx),
			.found_o(loFound)
		);

		oldestSelect #(.RADIX(HI)) upper (
			.elig_i (elig_i[RADIX-1:LO]),
			.ages_i (ages_i[RADIX-1:LO]),
			.age_o  (hiAge),
			.idx_o  (hiIdx),
			.found_o(hiFound)
		);

		// Upper half needs a strictly larger age, so ties go to the lower slot.
		assign takeHi = hiFound & (~loFound | (hiAge > loAge));

		assign age_o   = takeHi ? hiAge : loAge;
		assign idx_o   = takeHi ? hiIdx + IDX_WIDTH'(LO) : loIdx;
		assign found_o = loFound | hiFound;

	end

endmodule

/* design/issueQueue.sv */
`timescale 1ns/1ps

module issueQueue import coreParamsPkg::*, uopPkg::*; (
	input  logic                 clk,
	input  logic                 arstN_i,
	input  logic                 dispatchValid_i,
	input  uopT                  dispatchUop_i,
	input  logic                 wakeupValid_i,
	input  logic [TAG_WIDTH-1:0] wakeupTag_i,
	output logic                 full_o,
	output logic                 issueValid_o,
	output uopT                  issueUop_o
);

	entryT entries [NUM_ENTRIES];

	logic [NUM_ENTRIES-1:0]                validVec;
	logic [NUM_ENTRIES-1:0]                eligVec;
	logic [NUM_ENTRIES-1:0][AGE_WIDTH-1:0] ageVec;
	logic [NUM_ENTRIES-1:0]                wakeupHit;
	logic [NUM_ENTRIES-1:0]                issueSlot;

	logic [NUM_ENTRIES-1:0] allocGrant;
	logic                   anyFree;
	logic                   dispatchAccept;
	entryT                  newEntry;

	logic [IDX_WIDTH-1:0] pickIdx;
	logic                 pickFound;
	uopT                  pickUop;

	logic issueValidQ;
	uopT  issueUopQ;

	// ************************************************************
	// per-slot status
	// ************************************************************

	always_comb begin
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			validVec[i]  = entries[i].valid;
			eligVec[i]   = entries[i].valid & entries[i].ready;
			ageVec[i]    = entries[i].age;
			wakeupHit[i] = wakeupValid_i && (wakeupTag_i == entries[i].uop.srcTag);
			issueSlot[i] = pickFound && (pickIdx == IDX_WIDTH'(i));
		end
	end

	assign full_o = &validVec;

	// ************************************************************
	// allocation
	// ************************************************************

	prioritySelect #(.RADIX(NUM_ENTRIES)) allocator0 (
		.reqs_i    (~validVec),
		.grant_o   (allocGrant),
		.grantIdx_o(),
		.any_o     (anyFree)
	);

	assign dispatchAccept = dispatchValid_i & anyFree; // dropped when full.

	// A wakeup arriving with the dispatch still marks the new entry ready.
	always_comb begin
		newEntry       = '0;
		newEntry.valid = 1'b1;
		newEntry.ready = dispatchUop_i.srcReady |
			(wakeupValid_i && (wakeupTag_i == dispatchUop_i.srcTag));
		newEntry.age   = '0;
		newEntry.uop   = dispatchUop_i;
	end

	// ************************************************************
	// selection
	// ************************************************************

	oldestSelect #(.RADIX(NUM_ENTRIES)) picker0 (
		.elig_i (eligVec),
		.ages_i (ageVec),
		.age_o  (),
		.idx_o  (pickIdx),
		.found_o(pickFound)
	);

	assign pickUop = entries[pickIdx].uop;

	// ************************************************************
	// entry storage
	// ************************************************************

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				entries[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				if (dispatchAccept && allocGrant[i]) begin
					entries[i] <= newEntry; // only a free slot is granted.
				end else if (issueSlot[i]) begin
					entries[i].valid <= 1'b0; // leaves the queue this edge.
				end else if (entries[i].valid) begin
					entries[i].ready <= entries[i].ready | wakeupHit[i];
					if (entries[i].age != AGE_MAX) begin
						entries[i].age <= entries[i].age + 1'b1;
					end
				end
			end
		end
	end

	// ************************************************************
	// issue registers
	// ************************************************************

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			issueValidQ <= 1'b0;
		end else begin
			issueValidQ <= pickFound; // no back-pressure on the issue side.
		end
	end

	always_ff @(posedge clk) begin
		if (pickFound) begin
			issueUopQ <= pickUop;
		end
	end

	assign issueValid_o = issueValidQ;
	assign issueUop_o   = issueUopQ;

endmodule

/* design/issueUnit.sv */
`timescale 1ns/1ps

module issueUnit import coreParamsPkg::*, uopPkg::*; (
	input  logic                 clk,
	input  logic                 arstN_i,
	input  logic                 dispatchValid_i,
	input  uopT                  dispatchUop_i,
	input  logic                 wakeupValid_i,
	input  logic [TAG_WIDTH-1:0] wakeupTag_i,
	output logic                 full_o,
	output logic                 issueValid_o,
	output uopT                  issueUop_o
);

	logic queueFull;
	logic queueIssueValid;
	uopT  queueIssueUop;

	// ************************************************************
	// integer queue
	// ************************************************************

	// A second queue would sit beside this one and share the wakeup bus.
	issueQueue queue0 (
		.clk            (clk),
		.arstN_i        (arstN_i),
		.dispatchValid_i(dispatchValid_i),
		.dispatchUop_i  (dispatchUop_i),
		.wakeupValid_i  (wakeupValid_i),
		.wakeupTag_i    (wakeupTag_i),
		.full_o         (queueFull),
		.issueValid_o   (queueIssueValid),
		.issueUop_o     (queueIssueUop)
	);

	assign full_o       = queueFull;
	assign issueValid_o = queueIssueValid;
	assign issueUop_o   = queueIssueUop;

endmodule

/* tests/issueModel.svh */
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// ************************************************************
// reference model of the issue queue
// ************************************************************

localparam int MODEL_AGE_LIMIT = 15; // ages stop counting here.

logic mValid [NUM_ENTRIES];
logic mReady [NUM_ENTRIES];
int   mAge   [NUM_ENTRIES];
uopT  mUop   [NUM_ENTRIES];
logic expIssueValid;
uopT  expIssueUop;
logic expFull;

task automatic resetModel();
	for (int i = 0; i < NUM_ENTRIES; i++) begin
		mValid[i] = 1'b0;
		mReady[i] = 1'b0;
		mAge[i]   = 0;
		mUop[i]   = '0;
	end
	expIssueValid = 1'b0;
	expIssueUop   = '0;
	expFull       = 1'b0;
endtask

function automatic int countValid();
	int n;
	n = 0;
	for (int i = 0; i < NUM_ENTRIES; i++) begin
		if (mValid[i]) begin
			n++;
		end
	end
	return n;
endfunction

// Each rising edge picks the oldest ready entry, ages the rest and then accepts a dispatch.
task automatic stepModel(input logic dv, input uopT du, input logic wv,
	input logic [TAG_WIDTH-1:0] wt);
	int   pick;
	int   slot;
	logic wasFull;
	pick    = -1;
	slot    = -1;
	wasFull = (countValid() == NUM_ENTRIES);
	for (int i = 0; i < NUM_ENTRIES; i++) begin
		if (mValid[i] && mReady[i] && (pick < 0 || mAge[i] > mAge[pick])) begin
			pick = i; // strictly older only, so ties keep the lower slot.
		end
		if (!mValid[i] && slot < 0) begin
			slot = i;
		end
	end
	expIssueValid = (pick >= 0);
	if (pick >= 0) begin
		expIssueUop = mUop[pick];
	end
	for (int i = 0; i < NUM_ENTRIES; i++) begin
		if (i == pick) begin
			mValid[i] = 1'b0;
		end else if (mValid[i]) begin
			if (wv && wt == mUop[i].srcTag) begin
				mReady[i] = 1'b1;
			end
			if (mAge[i] < MODEL_AGE_LIMIT) begin
				mAge[i] = mAge[i] + 1;
			end
		end
	end
	if (dv && !wasFull) begin
		mValid[slot] = 1'b1;
		mReady[slot] = du.srcReady | (wv && wt == du.srcTag);
		mAge[slot]   = 0;
		mUop[slot]   = du;
	end
	expFull = (countValid() == NUM_ENTRIES);
endtask

`endif

/* tests/issueUnitTb.sv */
`timescale 1ns/1ps

module issueUnitTb import coreParamsPkg::*, uopPkg::*; ();

	localparam int CLK_PERIOD      = 20;
	localparam int RESET_CYCLES    = 2;
	localparam int RANDOM_CYCLES   = 300;
	localparam int TEST_CYCLES     = 10 + 10 + 25 + 70 + 40 + RANDOM_CYCLES + 30;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

	logic                 clk;
	logic                 arstN;
	logic                 dispatchValid;
	uopT                  dispatchUop;
	logic                 wakeupValid;
	logic [TAG_WIDTH-1:0] wakeupTag;
	logic                 full;
	logic                 issueValid;
	uopT                  issueUop;

	string                testName;
	int                   seed;
	logic                 watchDropped;
	logic [TAG_WIDTH-1:0] droppedDst;

	`include "issueModel.svh"

	issueUnit dut0 (
		.clk            (clk),
		.arstN_i        (arstN),
		.dispatchValid_i(dispatchValid),
		.dispatchUop_i  (dispatchUop),
		.wakeupValid_i  (wakeupValid),
		.wakeupTag_i    (wakeupTag),
		.full_o         (full),
		.issueValid_o   (issueValid),
		.issueUop_o     (issueUop)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resetModel();
		end else begin
			stepModel(dispatchValid, dispatchUop, wakeupValid, wakeupTag);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		reportFailure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
	end

	// ************************************************************
	// helpers
	// ************************************************************

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic uopT makeUop(input logic [OP_WIDTH-1:0] op,
		input logic [TAG_WIDTH-1:0] src, input logic rdy, input logic [TAG_WIDTH-1:0] dst);
		uopT u;
		u.opcode   = op;
		u.srcTag   = src;
		u.srcReady = rdy;
		u.dstTag   = dst;
		return u;
	endfunction

	task automatic checkCycle();
		assert (issueValid === expIssueValid) else reportFailure($sformatf(
			"Mismatch %s issueValid_o expected %0b actual %0b", testName, expIssueValid, issueValid));
		assert (full === expFull) else reportFailure($sformatf(
			"Mismatch %s full_o expected %0b actual %0b", testName, expFull, full));
		if (expIssueValid) begin
			assert (issueUop === expIssueUop) else reportFailure($sformatf(
				"Mismatch %s issueUop_o expected %h actual %h", testName, expIssueUop, issueUop));
		end
		if (watchDropped) begin
			assert (!(issueValid && issueUop.dstTag == droppedDst)) else reportFailure(
				$sformatf("%s: a micro-op dispatched while full was issued", testName));
		end
	endtask

	// Outputs are checked at the falling edge, then the next inputs go out.
	task automatic driveCycle(input logic dv, input uopT du, input logic wv,
		input logic [TAG_WIDTH-1:0] wt);
		@(negedge clk);
		checkCycle();
		dispatchValid = dv;
		dispatchUop   = du;
		wakeupValid   = wv;
		wakeupTag     = wt;
	endtask

	task automatic driveIdle();
		driveCycle(1'b0, '0, 1'b0, '0);
	endtask

	task automatic waitForIssue(input int maxCycles);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < maxCycles && !seen; i++) begin
			driveIdle();
			seen = issueValid;
		end
		if (!seen) begin
			reportFailure($sformatf("%s: nothing issued within %0d cycles", testName, maxCycles));
		end
	endtask

	task automatic waitDrain(input int maxCycles);
		int n;
		n = 0;
		while ((countValid() != 0 || issueValid) && n < maxCycles) begin
			driveIdle();
			n++;
		end
		if (countValid() != 0 || issueValid) begin
			reportFailure($sformatf("%s: queue still busy after %0d cycles", testName, maxCycles));
		end
	endtask

	// ************************************************************
	// tests
	// ************************************************************

	task automatic checkIdleAfterReset();
		testName = "resetIdle";
		repeat (5) driveIdle();
	endtask

	task automatic issueReadyUop();
		testName = "readyIssue";
		driveCycle(1'b1, makeUop(8'hA5, 6'd3, 1'b1, 6'd9), 1'b0, '0);
		waitForIssue(4);
		waitDrain(4);
	endtask

	task automatic releaseOnWakeup();
		testName = "wakeup";
		driveCycle(1'b1, makeUop(8'h31, 6'd12, 1'b0, 6'd17), 1'b0, '0);
		repeat (4) driveIdle();
		driveCycle(1'b0, '0, 1'b1, 6'd13); // a different tag leaves the entry waiting.
		repeat (3) driveIdle();
		driveCycle(1'b0, '0, 1'b1, 6'd12);
		waitForIssue(3);
		driveCycle(1'b1, makeUop(8'h32, 6'd14, 1'b0, 6'd18), 1'b1, 6'd14);
		waitForIssue(3);
		waitDrain(4);
	endtask

	task automatic issueInAgeOrder();
		testName = "ageOrder";
		for (int i = 0; i < 4; i++) begin
			driveCycle(1'b1, makeUop(OP_WIDTH'(8'h41 + i), 6'd20, 1'b0, TAG_WIDTH'(40 + i)),
				1'b0, '0);
		end
		repeat (3) driveIdle();
		driveCycle(1'b0, '0, 1'b1, 6'd20);
		waitDrain(10);
		testName = "saturatedOrder";
		for (int i = 0; i < 4; i++) begin
			driveCycle(1'b1, makeUop(OP_WIDTH'(8'h61 + i), 6'd21, 1'b0, TAG_WIDTH'(44 + i)),
				1'b0, '0);
		end
		repeat (20) driveIdle(); // long enough for every age to reach its limit.
		driveCycle(1'b0, '0, 1'b1, 6'd21);
		waitDrain(10);
	endtask

	task automatic dropWhenFull();
		testName = "fullDrop";
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			driveCycle(1'b1, makeUop(OP_WIDTH'(8'h50 + i), 6'd30, 1'b0, TAG_WIDTH'(32 + i)),
				1'b0, '0);
		end
		driveIdle();
		assert (full) else reportFailure("full_o stayed low with eight entries waiting");
		droppedDst   = 6'd63;
		watchDropped = 1'b1;
		driveCycle(1'b1, makeUop(8'hEE, 6'd5, 1'b1, droppedDst), 1'b0, '0);
		driveCycle(1'b0, '0, 1'b1, 6'd30);
		driveIdle();
		driveCycle(1'b1, makeUop(8'h5F, 6'd7, 1'b1, 6'd50), 1'b0, '0);
		waitDrain(NUM_ENTRIES + 6);
		watchDropped = 1'b0;
	endtask

	task automatic randomMix(input int cycles);
		logic                 dv;
		logic                 wv;
		logic [TAG_WIDTH-1:0] wt;
		uopT                  u;
		testName = "randomMix";
		for (int n = 0; n < cycles; n++) begin
			dv         = 1'($random(seed));
			wv         = 1'($random(seed));
			wt         = TAG_WIDTH'($random(seed) & 7);
			u.opcode   = OP_WIDTH'($random(seed));
			u.srcTag   = TAG_WIDTH'($random(seed) & 7); // small tag range so wakeups hit.
			u.srcReady = (($random(seed) & 3) == 0);
			u.dstTag   = TAG_WIDTH'($random(seed));
			driveCycle(dv, u, wv, wt);
		end
		for (int t = 0; t < 8; t++) begin
			driveCycle(1'b0, '0, 1'b1, TAG_WIDTH'(t));
		end
		waitDrain(NUM_ENTRIES + 4);
	endtask

	// ************************************************************
	// main sequence
	// ************************************************************

	initial begin
		arstN         = 1'b0;
		dispatchValid = 1'b0;
		dispatchUop   = '0;
		wakeupValid   = 1'b0;
		wakeupTag     = '0;
		testName      = "reset";
		seed          = 3793;
		watchDropped  = 1'b0;
		droppedDst    = '0;
		resetModel();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		checkIdleAfterReset();
		issueReadyUop();
		releaseOnWakeup();
		issueInAgeOrder();
		dropWhenFull();
		randomMix(RANDOM_CYCLES);
		driveIdle();
		$display("sim passed");
		$finish;
	end

endmodule

/* project.f */
+incdir+tests
design/coreParamsPkg.sv
design/uopPkg.sv
design/prioritySelect.sv
design/oldestSelect.sv
design/issueQueue.sv
design/issueUnit.sv
tests/issueUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the issue unit testbench with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module issueUnitTb \
	-f project.f -Mdir obj_dir \
	&& ./obj_dir/VissueUnitTb | tee sim.log \
	|| { echo "build or run error"; exit 1; }

grep -q "^sim passed$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
